// File: design/lpc_pkg.sv
package lpc_pkg;

	// One captured cycle is {address[31:0], data[7:0], 4'b0000, cyctype_dir[3:0]}.
	localparam int RECORD_WIDTH = 48;
	localparam int RECORD_BYTES = 6;

	// START nibble, sampled while lpc_frame is low.
	localparam logic [3:0] LPC_START = 4'h0;

	// Cycle type codes, found in bits 3:2 of the cycle type/direction nibble.
	localparam logic [1:0] CYC_IO = 2'b00;
	localparam logic [1:0] CYC_MEM = 2'b01;

	// Bit 1 of the cycle type/direction nibble. Set means a host write.
	localparam logic DIR_WRITE = 1'b1;

	localparam int IO_ADDR_NIBBLES = 4;
	localparam int MEM_ADDR_NIBBLES = 8;

	// SYNC values a peripheral drives on a read.
	localparam logic [3:0] SYNC_READY = 4'h0;
	localparam logic [3:0] SYNC_WAIT = 4'h6;

endpackage

// File: design/uart_pkg.sv
package uart_pkg;

	localparam int UART_DATA_BITS = 8;

	// Start bit, data bits and one stop bit.
	localparam int UART_FRAME_BITS = 10;

	// Line level between frames, also the stop bit level.
	localparam logic UART_IDLE = 1'b1;

endpackage

// File: design/lpc_decoder.sv
`timescale 1ns/1ps

module lpc_decoder (
	input  logic                              clock,
	input  logic                              rst,
	input  logic [3:0]                        lpc_ad,
	input  logic                              lpc_clock,
	input  logic                              lpc_frame,
	input  logic                              lpc_reset,
	output logic [lpc_pkg::RECORD_WIDTH-1:0]  record,
	output logic                              record_valid
);
	import lpc_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CYCTYPE,
		ST_ADDR,
		ST_TAR,
		ST_SYNC,
		ST_DATA_LO,
		ST_DATA_HI
	} state_t;

	state_t state;
	logic [2:0] nibble_count;

	logic [3:0] ad_meta;
	logic [3:0] ad_sync;
	logic clk_meta;
	logic clk_sync;
	logic clk_prev;
	logic frame_meta;
	logic frame_sync;
	logic lreset_meta;
	logic lreset_sync;
	logic lpc_edge;

	logic [3:0] cyctype_dir;
	logic [31:0] address;
	logic [3:0] data_lo;

	// The LPC pins are asynchronous to clock, so every pin goes through two flops.
	always_ff @(posedge clock) begin
		ad_meta <= lpc_ad;
		ad_sync <= ad_meta;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			clk_meta <= 1'b0;
			clk_sync <= 1'b0;
			clk_prev <= 1'b0;
			frame_meta <= 1'b1;
			frame_sync <= 1'b1;
			lreset_meta <= 1'b0;
			lreset_sync <= 1'b0;
		end else begin
			clk_meta <= lpc_clock;
			clk_sync <= clk_meta;
			clk_prev <= clk_sync;
			frame_meta <= lpc_frame;
			frame_sync <= frame_meta;
			lreset_meta <= lpc_reset;
			lreset_sync <= lreset_meta;
		end
	end

	assign lpc_edge = clk_sync && !clk_prev;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= ST_IDLE;
			nibble_count <= '0;
			record_valid <= 1'b0;
		end else begin
			record_valid <= 1'b0;
			if (!lreset_sync) begin
				state <= ST_IDLE;
			end else if (lpc_edge) begin
				// A low frame restarts the cycle, whatever state the FSM is in.
				if (!frame_sync) begin
					state <= (ad_sync == LPC_START) ? ST_CYCTYPE : ST_IDLE;
				end else begin
					case (state)
						ST_CYCTYPE: begin
							if (ad_sync[3:2] == CYC_IO) begin
								nibble_count <= 3'(IO_ADDR_NIBBLES - 1);
								state <= ST_ADDR;
							end else if (ad_sync[3:2] == CYC_MEM) begin
								nibble_count <= 3'(MEM_ADDR_NIBBLES - 1);
								state <= ST_ADDR;
							end else begin
								// DMA and bus master cycles wait here for the next frame.
								state <= ST_IDLE;
							end
						end
						ST_ADDR: begin
							if (nibble_count == '0) begin
								nibble_count <= 3'd1;
								state <= (cyctype_dir[1] == DIR_WRITE) ? ST_DATA_LO : ST_TAR;
							end else begin
								nibble_count <= nibble_count - 3'd1;
							end
						end
						ST_TAR: begin
							if (nibble_count == '0) begin
								state <= ST_SYNC;
							end else begin
								nibble_count <= nibble_count - 3'd1;
							end
						end
						ST_SYNC: begin
							if (ad_sync == SYNC_READY) begin
								state <= ST_DATA_LO;
							end else if (ad_sync != SYNC_WAIT) begin
								state <= ST_IDLE;
							end
						end
						ST_DATA_LO: state <= ST_DATA_HI;
						ST_DATA_HI: begin
							record_valid <= 1'b1;
							state <= ST_IDLE;
						end
						default: state <= ST_IDLE;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (lpc_edge && frame_sync) begin
			case (state)
				ST_CYCTYPE: begin
					cyctype_dir <= ad_sync;
					address <= '0;
				end
				// Address nibbles arrive MSB first; I/O addresses end up zero-extended.
				ST_ADDR: address <= {address[27:0], ad_sync};
				ST_DATA_LO: data_lo <= ad_sync;
				ST_DATA_HI: record <= {address, ad_sync, data_lo, 4'b0000, cyctype_dir};
				default: ;
			endcase
		end
	end

endmodule

// File: design/record_ring_buffer.sv
`timescale 1ns/1ps

module record_ring_buffer #(
	parameter int BUFFER_ADDR_WIDTH = 10
) (
	input  logic                              clock,
	input  logic                              rst,
	input  logic                              write,
	input  logic [lpc_pkg::RECORD_WIDTH-1:0]  write_data,
	input  logic                              read,
	output logic [lpc_pkg::RECORD_WIDTH-1:0]  read_data,
	output logic                              empty,
	output logic                              overflow
);
	import lpc_pkg::*;

	localparam int DEPTH = 2 ** BUFFER_ADDR_WIDTH;

	logic [RECORD_WIDTH-1:0] mem [DEPTH];
	logic [BUFFER_ADDR_WIDTH-1:0] write_ptr;
	logic [BUFFER_ADDR_WIDTH-1:0] read_ptr;
	logic [BUFFER_ADDR_WIDTH:0] count;
	logic full;
	logic do_write;
	logic do_read;

	assign full = count == (BUFFER_ADDR_WIDTH + 1)'(DEPTH);
	assign empty = count == '0;
	assign do_write = write && !full;
	assign do_read = read && !empty;

	always_ff @(posedge clock) begin
		if (rst) begin
			write_ptr <= '0;
			read_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_write) begin
				write_ptr <= write_ptr + 1'b1;
			end
			if (do_read) begin
				read_ptr <= read_ptr + 1'b1;
			end
			if (do_write && !do_read) begin
				count <= count + 1'b1;
			end else if (do_read && !do_write) begin
				count <= count - 1'b1;
			end
			// The record is lost; the flag stays up until rst.
			if (write && full) begin
				overflow <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_write) begin
			mem[write_ptr] <= write_data;
		end
		if (do_read) begin
			read_data <= mem[read_ptr];
		end
	end

endmodule

// File: design/record_serializer.sv
`timescale 1ns/1ps

module record_serializer (
	input  logic                                clock,
	input  logic                                rst,
	input  logic                                empty,
	output logic                                read,
	input  logic [lpc_pkg::RECORD_WIDTH-1:0]    read_data,
	input  logic                                ready,
	output logic                                send,
	output logic [uart_pkg::UART_DATA_BITS-1:0] tx_byte
);
	import lpc_pkg::*;
	import uart_pkg::*;

	localparam int COUNT_W = $clog2(RECORD_BYTES);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SEND
	} state_t;

	state_t state;
	logic [COUNT_W-1:0] byte_count;
	logic [RECORD_WIDTH-1:0] hold;

	// The buffer answers a read one cycle later, which is the ST_LOAD cycle.
	assign read = (state == ST_IDLE) && !empty;
	assign send = (state == ST_SEND) && ready;
	assign tx_byte = hold[RECORD_WIDTH-1 -: UART_DATA_BITS];

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= ST_IDLE;
			byte_count <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (read) begin
						state <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					byte_count <= '0;
					state <= ST_SEND;
				end
				ST_SEND: begin
					if (send) begin
						if (byte_count == COUNT_W'(RECORD_BYTES - 1)) begin
							state <= ST_IDLE;
						end else begin
							byte_count <= byte_count + 1'b1;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Bytes leave from the top of the record, so shift left after each one.
	always_ff @(posedge clock) begin
		if (state == ST_LOAD) begin
			hold <= read_data;
		end else if (send) begin
			hold <= hold << UART_DATA_BITS;
		end
	end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLOCK_FREQ = 12000000,
	parameter int BAUD_RATE = 115200
) (
	input  logic                                clock,
	input  logic                                rst,
	input  logic                                send,
	input  logic [uart_pkg::UART_DATA_BITS-1:0] tx_byte,
	output logic                                ready,
	output logic                                tx
);
	import uart_pkg::*;

	localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
	localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam int BIT_W = $clog2(UART_FRAME_BITS);

	logic busy;
	logic [BAUD_W-1:0] baud_count;
	logic [BIT_W-1:0] bit_count;
	logic [UART_FRAME_BITS-2:0] frame;
	logic bit_done;

	assign ready = !busy;
	assign bit_done = baud_count == BAUD_W'(CLKS_PER_BIT - 1);

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			baud_count <= '0;
			bit_count <= '0;
			tx <= UART_IDLE;
		end else if (!busy) begin
			if (send) begin
				busy <= 1'b1;
				baud_count <= '0;
				bit_count <= '0;
				tx <= ~UART_IDLE;
			end
		end else if (bit_done) begin
			baud_count <= '0;
			if (bit_count == BIT_W'(UART_FRAME_BITS - 1)) begin
				busy <= 1'b0;
			end else begin
				bit_count <= bit_count + 1'b1;
				tx <= frame[0];
			end
		end else begin
			baud_count <= baud_count + 1'b1;
		end
	end

	// Data bits go out LSB first and the stop bit trails them.
	always_ff @(posedge clock) begin
		if (!busy && send) begin
			frame <= {UART_IDLE, tx_byte};
		end else if (busy && bit_done) begin
			frame <= {UART_IDLE, frame[UART_FRAME_BITS-2:1]};
		end
	end

endmodule

// File: design/activity_stretcher.sv
`timescale 1ns/1ps

module activity_stretcher #(
	parameter int LED_HOLD_CYCLES = 1200000
) (
	input  logic clock,
	input  logic rst,
	input  logic trigger,
	output logic led
);
	localparam int COUNT_W = $clog2(LED_HOLD_CYCLES + 1);

	logic [COUNT_W-1:0] count;

	// A new trigger restarts the full hold time.
	always_ff @(posedge clock) begin
		if (rst) begin
			count <= '0;
		end else if (trigger) begin
			count <= COUNT_W'(LED_HOLD_CYCLES);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign led = count != '0;

endmodule

// File: design/lpc_sniffer.sv
`timescale 1ns/1ps

module lpc_sniffer #(
	parameter int CLOCK_FREQ = 12000000,
	parameter int BAUD_RATE = 115200,
	parameter int BUFFER_ADDR_WIDTH = 10,
	parameter int LED_HOLD_CYCLES = 1200000
) (
	input  logic       clock,
	input  logic       rst,
	input  logic [3:0] lpc_ad,
	input  logic       lpc_clock,
	input  logic       lpc_frame,
	input  logic       lpc_reset,
	output logic       uart_tx_pin,
	output logic       capture_led,
	output logic       overflow_led
);
	import lpc_pkg::*;
	import uart_pkg::*;

	logic [RECORD_WIDTH-1:0] record;
	logic record_valid;
	logic [RECORD_WIDTH-1:0] read_data;
	logic read;
	logic empty;
	logic ready;
	logic send;
	logic [UART_DATA_BITS-1:0] tx_byte;

	lpc_decoder u_decoder (
		.clock        (clock),
		.rst          (rst),
		.lpc_ad       (lpc_ad),
		.lpc_clock    (lpc_clock),
		.lpc_frame    (lpc_frame),
		.lpc_reset    (lpc_reset),
		.record       (record),
		.record_valid (record_valid)
	);

	record_ring_buffer #(
		.BUFFER_ADDR_WIDTH (BUFFER_ADDR_WIDTH)
	) u_ring_buffer (
		.clock      (clock),
		.rst        (rst),
		.write      (record_valid),
		.write_data (record),
		.read       (read),
		.read_data  (read_data),
		.empty      (empty),
		.overflow   (overflow_led)
	);

	record_serializer u_serializer (
		.clock     (clock),
		.rst       (rst),
		.empty     (empty),
		.read      (read),
		.read_data (read_data),
		.ready     (ready),
		.send      (send),
		.tx_byte   (tx_byte)
	);

	uart_tx #(
		.CLOCK_FREQ (CLOCK_FREQ),
		.BAUD_RATE  (BAUD_RATE)
	) u_uart_tx (
		.clock   (clock),
		.rst     (rst),
		.send    (send),
		.tx_byte (tx_byte),
		.ready   (ready),
		.tx      (uart_tx_pin)
	);

	activity_stretcher #(
		.LED_HOLD_CYCLES (LED_HOLD_CYCLES)
	) u_capture_led (
		.clock   (clock),
		.rst     (rst),
		.trigger (record_valid),
		.led     (capture_led)
	);

endmodule

// File: tests/lpc_sniffer_tb.sv
`timescale 1ns/1ps

module lpc_sniffer_tb;
	import lpc_pkg::*;
	import uart_pkg::*;

	localparam int CLOCK_FREQ = 921600;
	localparam int BAUD_RATE = 115200;
	localparam int BUFFER_ADDR_WIDTH = 2;
	localparam int LED_HOLD_CYCLES = 64;

	localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
	localparam int FRAME_CYCLES = CLKS_PER_BIT * UART_FRAME_BITS;
	localparam int LPC_HALF = 4;
	localparam int LPC_ROW_CYCLES = 32 * 2 * LPC_HALF;
	localparam int QUIET_CYCLES = 3 * FRAME_CYCLES;
	localparam int LED_MARGIN = 8;
	localparam int IDLE_CHECK_CYCLES = 100;
	localparam int NUM_ROWS = 9;
	localparam int BURST_LEN = 10;
	localparam int TIMEOUT_CYCLES = 2 * ((NUM_ROWS + BURST_LEN) *
		(LPC_ROW_CYCLES + RECORD_BYTES * FRAME_CYCLES + QUIET_CYCLES) +
		4 * LED_HOLD_CYCLES) + 1000;

	typedef struct {
		string name;
		logic [1:0] cyc;
		logic wr;
		logic [31:0] addr;
		logic [7:0] data;
		int waits;
		logic abort;
		logic expect_rec;
		logic rand_fill;
		int count;
	} lpc_row_t;

	logic clock;
	logic rst;
	logic [3:0] lpc_ad;
	logic lpc_clock;
	logic lpc_frame;
	logic lpc_reset;
	logic uart_tx_pin;
	logic capture_led;
	logic overflow_led;

	lpc_row_t rows [NUM_ROWS];
	logic [RECORD_WIDTH-1:0] expected_q [$];
	int cycle = 0;
	int last_rx_cycle = 0;
	int rx_records = 0;
	int rx_bytes = 0;
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	logic rx_busy = 1'b0;
	logic drop_ok = 1'b0;
	logic led_seen = 1'b0;
	logic overflow_expected = 1'b0;

	lpc_sniffer #(
		.CLOCK_FREQ        (CLOCK_FREQ),
		.BAUD_RATE         (BAUD_RATE),
		.BUFFER_ADDR_WIDTH (BUFFER_ADDR_WIDTH),
		.LED_HOLD_CYCLES   (LED_HOLD_CYCLES)
	) u_lpc_sniffer (
		.clock        (clock),
		.rst          (rst),
		.lpc_ad       (lpc_ad),
		.lpc_clock    (lpc_clock),
		.lpc_frame    (lpc_frame),
		.lpc_reset    (lpc_reset),
		.uart_tx_pin  (uart_tx_pin),
		.capture_led  (capture_led),
		.overflow_led (overflow_led)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the run did not complete", cycle);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	always @(negedge clock) begin
		if (capture_led) begin
			led_seen = 1'b1;
		end
	end

	// The record holds the address, the data byte, four zero bits and the cycle type nibble.
	function automatic logic [RECORD_WIDTH-1:0] expected_record(input logic [1:0] cyc,
			input logic wr, input logic [31:0] addr, input logic [7:0] data);
		logic [31:0] full_addr;
		full_addr = (cyc == CYC_IO) ? {16'h0000, addr[15:0]} : addr;
		return {full_addr, data, 4'b0000, cyc, wr, 1'b0};
	endfunction

	// One LPC clock period, with the pins changing on the falling lpc_clock edge.
	task automatic lpc_tick(input logic frame, input logic [3:0] ad);
		@(posedge clock);
		lpc_clock <= 1'b0;
		lpc_frame <= frame;
		lpc_ad <= ad;
		repeat (LPC_HALF) @(posedge clock);
		lpc_clock <= 1'b1;
		repeat (LPC_HALF - 1) @(posedge clock);
	endtask

	task automatic run_lpc_cycle(input logic [1:0] cyc, input logic wr, input logic [31:0] addr,
			input logic [7:0] data, input int waits, input logic abort);
		int n_addr;
		n_addr = (cyc == CYC_IO) ? IO_ADDR_NIBBLES : MEM_ADDR_NIBBLES;
		lpc_tick(1'b0, LPC_START);
		lpc_tick(1'b1, {cyc, wr, 1'b0});
		for (int i = n_addr - 1; i >= 0; i--) begin
			// The host aborts halfway through the address by holding frame low.
			if (abort && i == n_addr / 2) begin
				repeat (4) lpc_tick(1'b0, 4'hF);
				lpc_tick(1'b1, 4'hF);
				return;
			end
			lpc_tick(1'b1, addr[4*i +: 4]);
		end
		if (wr) begin
			lpc_tick(1'b1, data[3:0]);
			lpc_tick(1'b1, data[7:4]);
			repeat (2) lpc_tick(1'b1, 4'hF);
			lpc_tick(1'b1, SYNC_READY);
			repeat (2) lpc_tick(1'b1, 4'hF);
		end else begin
			repeat (2) lpc_tick(1'b1, 4'hF);
			repeat (waits) lpc_tick(1'b1, SYNC_WAIT);
			lpc_tick(1'b1, SYNC_READY);
			lpc_tick(1'b1, data[3:0]);
			lpc_tick(1'b1, data[7:4]);
			repeat (2) lpc_tick(1'b1, 4'hF);
		end
	endtask

	task automatic check_record(input logic [RECORD_WIDTH-1:0] got);
		logic [RECORD_WIDTH-1:0] exp;
		if (drop_ok) begin
			// Dropped records leave gaps, but the survivors keep their order.
			while (expected_q.size() > 0 && expected_q[0] != got) begin
				void'(expected_q.pop_front());
			end
		end
		assert (expected_q.size() > 0) else begin
			$display("Record 0x%h arrived but no sent record is left to match it", got);
			error_count++;
		end
		if (expected_q.size() > 0) begin
			exp = expected_q.pop_front();
			assert (got == exp) else begin
				$display("Error: uart_tx_pin record got 0x%h expected 0x%h", got, exp);
				error_count++;
			end
		end
		rx_records++;
	endtask

	// Serial receiver, sampling each bit near its middle.
	initial begin : uart_receiver
		logic [7:0] rx_byte;
		logic [RECORD_WIDTH-1:0] got;
		int nbytes;
		nbytes = 0;
		got = '0;
		forever begin
			@(negedge clock);
			if (!rst && uart_tx_pin == 1'b0) begin
				rx_busy = 1'b1;
				repeat (CLKS_PER_BIT / 2 - 1) @(negedge clock);
				assert (uart_tx_pin == 1'b0) else begin
					$display("A start bit on uart_tx_pin ended before its middle");
					error_count++;
				end
				for (int b = 0; b < UART_DATA_BITS; b++) begin
					repeat (CLKS_PER_BIT) @(negedge clock);
					rx_byte[b] = uart_tx_pin;
				end
				repeat (CLKS_PER_BIT) @(negedge clock);
				assert (uart_tx_pin == UART_IDLE) else begin
					$display("Stop bit missing on uart_tx_pin after byte 0x%h", rx_byte);
					error_count++;
				end
				got = {got[RECORD_WIDTH-9:0], rx_byte};
				nbytes++;
				rx_bytes++;
				if (nbytes == RECORD_BYTES) begin
					nbytes = 0;
					check_record(got);
				end
				last_rx_cycle = cycle;
				rx_busy = 1'b0;
			end
		end
	end

	// Returns once the serial line has been idle for a few frame times.
	task automatic wait_quiet();
		int mark;
		mark = cycle;
		while (rx_busy ||
				cycle - ((last_rx_cycle > mark) ? last_rx_cycle : mark) < QUIET_CYCLES) begin
			@(negedge clock);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			pass_count++;
			$display("Test %s: passed", name);
		end else begin
			fail_count++;
			$display("Test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	initial begin : main
		int errors_before;
		int rx_before;
		int waits;
		int hold;
		logic [31:0] addr;
		logic [7:0] data;

		void'($urandom(82004));
		rows[0] = '{"io write", CYC_IO, 1'b1, 32'h0000_0080, 8'h5A, 0, 1'b0, 1'b1, 1'b0, 1};
		rows[1] = '{"io read with sync waits", CYC_IO, 1'b0, 32'hFFFF_03F8, 8'hC3, 3, 1'b0, 1'b1,
			1'b0, 1};
		rows[2] = '{"memory write", CYC_MEM, 1'b1, 32'h0, 8'h00, 0, 1'b0, 1'b1, 1'b1, 1};
		rows[3] = '{"memory read", CYC_MEM, 1'b0, 32'h0, 8'h00, 0, 1'b0, 1'b1, 1'b1, 1};
		rows[4] = '{"memory read long wait", CYC_MEM, 1'b0, 32'hFFFF_FF00, 8'hA5, 9, 1'b0, 1'b1,
			1'b0, 1};
		// Cycle type 2 is DMA, which the decoder skips.
		rows[5] = '{"dma cycle skipped", 2'b10, 1'b1, 32'h0000_1234, 8'h77, 0, 1'b0, 1'b0, 1'b0, 1};
		rows[6] = '{"aborted memory write", CYC_MEM, 1'b1, 32'hDEAD_BEEF, 8'h3C, 0, 1'b1, 1'b0,
			1'b0, 1};
		rows[7] = '{"io write after skips", CYC_IO, 1'b1, 32'h0000_0070, 8'h11, 0, 1'b0, 1'b1,
			1'b0, 1};
		rows[8] = '{"overflow burst", CYC_MEM, 1'b1, 32'h0, 8'h00, 0, 1'b0, 1'b1, 1'b1, BURST_LEN};

		rst = 1'b1;
		lpc_ad = 4'hF;
		lpc_clock = 1'b0;
		lpc_frame = 1'b1;
		lpc_reset = 1'b0;
		repeat (8) @(posedge clock);
		rst <= 1'b0;
		lpc_reset <= 1'b1;

		errors_before = error_count;
		repeat (IDLE_CHECK_CYCLES) begin
			@(negedge clock);
			assert (uart_tx_pin == 1'b1 && capture_led == 1'b0 && overflow_led == 1'b0) else begin
				$display("Error: outputs after reset got tx/capture/overflow 0x%h expected 0x4",
					{uart_tx_pin, capture_led, overflow_led});
				error_count++;
			end
		end
		assert (rx_bytes == 0) else begin
			$display("A byte arrived while the LPC bus was idle");
			error_count++;
		end
		report_test("reset state", errors_before);

		for (int r = 0; r < NUM_ROWS; r++) begin
			errors_before = error_count;
			rx_before = rx_records;
			led_seen = 1'b0;
			drop_ok = rows[r].count > 1;
			for (int n = 0; n < rows[r].count; n++) begin
				addr = rows[r].addr;
				data = rows[r].data;
				waits = rows[r].waits;
				if (rows[r].rand_fill) begin
					addr = $urandom;
					data = 8'($urandom);
					waits = $urandom % 4;
				end
				if (rows[r].expect_rec) begin
					expected_q.push_back(expected_record(rows[r].cyc, rows[r].wr, addr, data));
				end
				run_lpc_cycle(rows[r].cyc, rows[r].wr, addr, data, waits, rows[r].abort);
			end
			wait_quiet();
			if (drop_ok) begin
				assert (rx_records - rx_before >= 2 ** BUFFER_ADDR_WIDTH) else begin
					$display("Only %0d records came out of the burst", rx_records - rx_before);
					error_count++;
				end
				expected_q.delete();
				overflow_expected = 1'b1;
			end
			assert (expected_q.size() == 0) else begin
				$display("%0d expected records never arrived", expected_q.size());
				error_count++;
				expected_q.delete();
			end
			assert (overflow_led == overflow_expected) else begin
				$display("Error: overflow_led got 0x%h expected 0x%h", overflow_led,
					overflow_expected);
				error_count++;
			end
			assert (led_seen == rows[r].expect_rec) else begin
				$display("Error: capture_led seen got 0x%h expected 0x%h", led_seen,
					rows[r].expect_rec);
				error_count++;
			end
			report_test(rows[r].name, errors_before);
		end

		errors_before = error_count;
		drop_ok = 1'b0;
		addr = 32'h0000_0080;
		data = 8'($urandom);
		expected_q.push_back(expected_record(CYC_IO, 1'b1, addr, data));
		run_lpc_cycle(CYC_IO, 1'b1, addr, data, 0, 1'b0);
		wait (capture_led == 1'b1);
		hold = 0;
		while (capture_led) begin
			@(negedge clock);
			hold++;
		end
		assert (hold <= LED_HOLD_CYCLES + LED_MARGIN) else begin
			$display("capture_led stayed on for %0d cycles after the last record", hold);
			error_count++;
		end
		repeat (LED_HOLD_CYCLES + LED_MARGIN) begin
			@(negedge clock);
			assert (capture_led == 1'b0) else begin
				$display("Error: capture_led got 0x%h expected 0x0", capture_led);
				error_count++;
			end
		end
		wait_quiet();
		assert (expected_q.size() == 0) else begin
			$display("The record for the capture LED test never arrived");
			error_count++;
		end
		assert (overflow_led == 1'b1) else begin
			$display("Error: overflow_led got 0x%h expected 0x1", overflow_led);
			error_count++;
		end
		report_test("capture led", errors_before);

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: src.f
design/lpc_pkg.sv
design/uart_pkg.sv
design/lpc_decoder.sv
design/record_ring_buffer.sv
design/record_serializer.sv
design/uart_tx.sv
design/activity_stretcher.sv
design/lpc_sniffer.sv
tests/lpc_sniffer_tb.sv

// File: Bender.yml
package:
  name: lpc_sniffer

sources:
  - files:
      - design/lpc_pkg.sv
      - design/uart_pkg.sv
      - design/lpc_decoder.sv
      - design/record_ring_buffer.sv
      - design/record_serializer.sv
      - design/uart_tx.sv
      - design/activity_stretcher.sv
      - design/lpc_sniffer.sv
  - target: test
    files:
      - tests/lpc_sniffer_tb.sv
